// File: bench/sound_codec_tb.sv
// Testbench for the audio block with an AXI4-Lite master, a tape ADC model and PWM counting
// Mix rows come from a fixed table plus LCG rows checked against the mixer rule
// An ADC value shows up in reg_adc only after two complete frames

`timescale 1ns/1ps

module sound_codec_tb;

    // ----------------------------------------
    // Run length
    // ----------------------------------------
    localparam int N_FIXED     = 9;
    localparam int N_RAND      = 6;
    localparam int N_ADC       = 9;
    // Two full frames plus a partial one per ADC value
    localparam int ADC_FRAMES  = 3 * N_ADC;
    localparam int CYCLE_LIMIT = (N_FIXED + N_RAND) * 5000 + ADC_FRAMES * 1024 + 2000;
    // 512 modulator enables
    localparam int DENS_CYCLES = 4096;

    // DUT ports
    logic        clk24;
    logic        rst;
    logic [3:0]  pulses;
    logic [7:0]  ay_a;
    logic [7:0]  ay_b;
    logic [7:0]  ay_c;
    logic [7:0]  rs_a;
    logic [7:0]  rs_b;
    logic [7:0]  rs_c;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        adc_data;
    logic        adc_clk;
    logic        adc_cs_n;
    logic        tapein;
    logic        pwm;

    // Port names match one to one
    sound_codec DUT (.*);

    // Stimulus table, channels packed as ay_a ay_b ay_c rs_a rs_b rs_c
    logic [3:0]  row_pulses[$];
    logic [47:0] row_chan[$];
    logic [7:0]  row_ctrl[$];
    logic [7:0]  row_covox[$];
    logic [15:0] row_level[$];
    logic [8:0]  row_dens[$];

    // Tape samples and the comparator state expected after each
    // Last three enter the band from above and from below
    logic [7:0]  adc_vals[N_ADC] = '{8'h5a, 8'd140, 8'd130, 8'd120, 8'd126, 8'd133,
                                     8'd126, 8'd120, 8'd130};
    logic        adc_taps[N_ADC] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1,
                                     1'b1, 1'b0, 1'b0};
    logic [7:0]  adc_value;
    logic [7:0]  shift_byte;

    int          errors      = 0;
    int          cs_errors   = 0;
    int          frames_done = 0;
    int          low_run     = 0;
    int          cycles      = 0;

    // ----------------------------------------
    // Clock, timeout
    // ----------------------------------------
    initial begin
        clk24 = 1'b0;
        forever #10 clk24 = ~clk24;
    end

    always @(posedge clk24) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Tape ADC model
    // ----------------------------------------

    // MSB shortly after chip select, next bit shortly after each falling adc_clk
    initial begin
        adc_data = 1'b0;
        forever begin
            @(negedge adc_cs_n);
            shift_byte = adc_value;
            for (int b = 7; b >= 0; b--) begin
                #2;
                adc_data = shift_byte[b];
                @(negedge adc_clk);
            end
        end
    end

    // Chip select width per frame, counted mid-cycle
    always @(negedge clk24) begin
        if (rst) begin
            low_run = 0;
        end else if (!adc_cs_n) begin
            low_run++;
        end else if (low_run != 0) begin
            if (low_run != 256) begin
                $display("[ERROR] adc_cs_n low clocks got %h expected %h", low_run, 256);
                cs_errors++;
            end
            frames_done++;
            low_run = 0;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Inputs move 2 ns after the rising edge
    task automatic tick();
        @(posedge clk24);
        #2;
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mixer gains and saturation, straight from the register spec
    function automatic int mix_rule(input logic [3:0] p, input logic [47:0] ch,
                                    input logic [7:0] ctrl, input logic [7:0] cov);
        int beep;
        int ay;
        int rs;
        int cv;
        int total;
        beep = (int'(p[0]) + int'(p[1]) + int'(p[2]) + 2 * int'(p[3])) * 8192;
        ay   = int'(ch[47:40]) + int'(ch[39:32]) + int'(ch[31:24]);
        rs   = int'(ch[23:16]) + int'(ch[15:8]) + int'(ch[7:0]);
        // Both chips at half gain once the second one is on
        if (ctrl[4]) begin
            ay = ay * 16;
            rs = rs * 16;
        end else begin
            ay = ay * 32;
            rs = 0;
        end
        cv = int'(cov) * 16;
        if (ctrl[0]) beep = 0;
        if (ctrl[1]) ay = 0;
        if (ctrl[2]) rs = 0;
        if (ctrl[3]) cv = 0;
        total = beep + ay + rs + cv;
        return (total > 65535) ? 65535 : total;
    endfunction

    task automatic add_row(input logic [3:0] p, input logic [47:0] ch, input logic [7:0] ctrl,
                           input logic [7:0] cov, input logic [15:0] lvl,
                           input logic [8:0] dens);
        row_pulses.push_back(p);
        row_chan.push_back(ch);
        row_ctrl.push_back(ctrl);
        row_covox.push_back(cov);
        row_level.push_back(lvl);
        row_dens.push_back(dens);
    endtask

    // Single-beat write with address and data together, bready held high
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic hs;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        hs      = 1'b0;
        while (!hs) begin
            @(negedge clk24);
            hs = awready && wready;
            tick();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        hs      = 1'b0;
        while (!hs) begin
            @(negedge clk24);
            hs   = bvalid;
            resp = bresp;
            tick();
        end
    endtask

    // Single-beat read, rready held low for stall cycles after rvalid
    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp, input int stall);
        logic hs;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (stall == 0);
        hs      = 1'b0;
        while (!hs) begin
            @(negedge clk24);
            hs = arready;
            tick();
        end
        arvalid = 1'b0;
        // Address moves off once accepted, held data must come from the capture
        araddr  = ~addr;
        hs      = 1'b0;
        while (!hs) begin
            @(negedge clk24);
            hs   = rvalid;
            data = rdata;
            resp = rresp;
            tick();
        end
        // Response must stay put under back-pressure
        repeat (stall) begin
            @(negedge clk24);
            if (!rvalid) begin
                $display("rvalid dropped while rready was held low");
                errors++;
            end
            compare_word("rdata under stall", rdata, data);
            tick();
        end
        if (stall > 0) begin
            rready = 1'b1;
            tick();
        end
    endtask

    // Counts completed frames, bounded by the cycle timeout
    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            tick();
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] seed;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] s3;
        logic [1:0]  resp;
        logic [1:0]  resp2;
        int          lvl;
        int          hi;
        int          d;

        rst       = 1'b1;
        pulses    = 4'h0;
        {ay_a, ay_b, ay_c, rs_a, rs_b, rs_c} = 48'h0;
        awaddr    = 4'h0;
        awvalid   = 1'b0;
        wdata     = 32'h0;
        wstrb     = 4'hf;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = 4'h0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        adc_value = 8'h00;

        // Fixed rows with hand-worked levels, density is level[15:7]
        add_row(4'h0, {8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0}, 8'h00, 8'h00, 16'h0000, 9'd0);
        add_row(4'h1, {8'd10, 8'd20, 8'd30, 8'd0, 8'd0, 8'd0}, 8'h00, 8'h00, 16'h2780, 9'd79);
        add_row(4'h8, {8'd100, 8'd100, 8'd100, 8'd50, 8'd50, 8'd50}, 8'h10, 8'h80,
                16'h6420, 9'd200);
        add_row(4'h8, {8'd100, 8'd100, 8'd100, 8'd50, 8'd50, 8'd50}, 8'h13, 8'h80,
                16'h1160, 9'd34);
        add_row(4'h8, {8'd100, 8'd100, 8'd100, 8'd50, 8'd50, 8'd50}, 8'h0c, 8'h80,
                16'h6580, 9'd203);
        add_row(4'h8, {8'd100, 8'd100, 8'd100, 8'd50, 8'd50, 8'd50}, 8'h04, 8'h80,
                16'h6d80, 9'd219);
        // All inputs at maximum, clipped, then everything muted
        add_row(4'hf, {6{8'hff}}, 8'h10, 8'hff, 16'hffff, 9'd511);
        add_row(4'hf, {6{8'hff}}, 8'h0f, 8'hff, 16'h0000, 9'd0);
        add_row(4'h0, {6{8'h00}}, 8'h00, 8'hff, 16'h0ff0, 9'd31);

        // LCG rows, upper bits only
        seed = 32'h85c1_5a87;
        for (int i = 0; i < N_RAND; i++) begin
            s1   = lcg_next(seed);
            s2   = lcg_next(s1);
            s3   = lcg_next(s2);
            seed = s3;
            lvl  = mix_rule(s1[31:28], {s2[31:8], s3[31:8]}, {3'b0, s1[20:16]}, s1[15:8]);
            add_row(s1[31:28], {s2[31:8], s3[31:8]}, {3'b0, s1[20:16]}, s1[15:8],
                    lvl[15:0], lvl[15:7]);
        end

        // Reset state on the first cycle with rst low
        repeat (8) @(posedge clk24);
        #2;
        rst = 1'b0;
        compare_word("reset {bvalid,rvalid,pwm,tapein,adc_clk,adc_cs_n}",
                     {26'h0, bvalid, rvalid, pwm, tapein, adc_clk, adc_cs_n}, 32'h1);
        tick();
        axi_read(regs_pkg::reg_ctrl, rd, resp, 0);
        compare_word("reg_ctrl after reset", rd, 32'h0);

        // ----------------------------------------
        // Register access
        // ----------------------------------------
        axi_write(regs_pkg::reg_ctrl, 32'h0000_0015, resp);
        compare_word("bresp reg_ctrl", {30'h0, resp}, 32'h0);
        axi_read(regs_pkg::reg_ctrl, rd, resp, 0);
        compare_word("reg_ctrl", rd, 32'h15);
        compare_word("rresp reg_ctrl", {30'h0, resp}, 32'h0);
        axi_write(regs_pkg::reg_covox, 32'h0000_00a5, resp);
        compare_word("bresp reg_covox", {30'h0, resp}, 32'h0);
        axi_read(regs_pkg::reg_covox, rd, resp, 6);
        compare_word("reg_covox", rd, 32'ha5);
        // Status registers and holes refuse access
        axi_write(regs_pkg::reg_level, 32'h0000_1234, resp);
        compare_word("bresp reg_level", {30'h0, resp}, 32'h2);
        axi_write(regs_pkg::reg_adc, 32'h0000_01ff, resp);
        compare_word("bresp reg_adc", {30'h0, resp}, 32'h2);
        axi_write(4'h2, 32'h0000_0003, resp);
        compare_word("bresp unknown", {30'h0, resp}, 32'h2);
        axi_read(4'h6, rd, resp, 0);
        compare_word("rresp unknown", {30'h0, resp}, 32'h2);
        axi_read(regs_pkg::reg_ctrl, rd, resp, 0);
        compare_word("reg_ctrl after refused writes", rd, 32'h15);

        // ----------------------------------------
        // Mix level and modulator density
        // ----------------------------------------
        for (int i = 0; i < row_level.size(); i++) begin
            pulses = row_pulses[i];
            {ay_a, ay_b, ay_c, rs_a, rs_b, rs_c} = row_chan[i];
            axi_write(regs_pkg::reg_ctrl, {24'h0, row_ctrl[i]}, resp);
            axi_write(regs_pkg::reg_covox, {24'h0, row_covox[i]}, resp2);
            if (resp != 2'd0 || resp2 != 2'd0) begin
                $display("Row %0d: a control write was refused", i);
                errors++;
            end
            // Let the old carry flush out of the modulator
            repeat (20) tick();
            axi_read(regs_pkg::reg_level, rd, resp, 0);
            compare_word("reg_level", rd, {16'h0, row_level[i]});
            hi = 0;
            repeat (DENS_CYCLES) begin
                @(negedge clk24);
                if (pwm) hi++;
            end
            tick();
            d = int'(row_dens[i]);
            if (d == 0 && hi != 0) begin
                $display("[ERROR] pwm high cycles got %h expected %h", hi, 0);
                errors++;
            end else if (hi / 8 < d - 1 || hi / 8 > d + 1) begin
                $display("[ERROR] pwm density got %h expected %h", hi / 8, d);
                errors++;
            end
        end

        // ----------------------------------------
        // ADC capture and hysteresis
        // ----------------------------------------
        for (int i = 0; i < N_ADC; i++) begin
            adc_value = adc_vals[i];
            wait_frames(2);
            axi_read(regs_pkg::reg_adc, rd, resp, 0);
            compare_word("reg_adc sample", {24'h0, rd[7:0]}, {24'h0, adc_vals[i]});
            compare_word("reg_adc tapein", {31'h0, rd[8]}, {31'h0, adc_taps[i]});
            compare_word("tapein", {31'h0, tapein}, {31'h0, adc_taps[i]});
        end

        $display("Errors %0d, frame errors %0d, rows %0d, ADC frames %0d",
                 errors, cs_errors, row_level.size(), frames_done);
        if (errors + cs_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
src/audio_pkg.sv
src/regs_pkg.sv
src/mix_cfg_if.sv
src/audio_regs.sv
src/sound_mixer.sv
src/delta_sigma_dac.sv
src/tape_adc_reader.sv
src/sound_codec.sv
bench/sound_codec_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only when the log holds the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module sound_codec_tb -Mdir obj_dir -f compile.f \
    && ./obj_dir/Vsound_codec_tb > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1

// File: src/audio_macros.svh
// Compile-time constants of the audio path
// Changing the ADC timing values also changes the frame length seen by the tape model
// The hysteresis is symmetric around mid-scale 128

`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// Tape comparator half-width in ADC counts
`define AUDIO_HYST 4

// Modulator input width taken from the top of the level
`define AUDIO_PWM_WIDTH 9

// Modulator enable on counter wrap, one per 8 clocks
`define AUDIO_DS_DIV_BITS 3

// ADC bit period of 32 clocks, adc_clk at 750 kHz
`define ADC_CLK_DIV_BITS 5

// Bit periods per ADC frame, 8 shifting then 24 converting
`define ADC_FRAME_BITS 32

`endif

// File: src/audio_pkg.sv
// Types of the sound signal path
// Mute mask bits follow the order of src_t

package audio_pkg;

    // ----------------------------------------
    // Samples and levels
    // ----------------------------------------

    // One channel sample from a music chip, covox or the tape ADC
    typedef logic [7:0] sample8_t;

    // Mixed output level, full scale 65535
    typedef logic [15:0] level_t;

    // ----------------------------------------
    // Source selection
    // ----------------------------------------

    // Mixer sources in mute mask bit order
    typedef enum logic [1:0] {
        src_beep  = 2'd0,
        src_ay    = 2'd1,
        src_rs    = 2'd2,
        src_covox = 2'd3
    } src_t;

    // One bit per source, set means silenced
    typedef logic [3:0] mute_t;

endpackage

// File: src/audio_regs.sv
// AXI4-Lite slave with single beats only
// Wstrb is not decoded and only full-word writes are expected
// Writes to status registers or unknown offsets answer slverr and change nothing

`timescale 1ns/1ps

module audio_regs (
    input  logic                clk24,
    input  logic                rst,
    // Write address and data
    input  regs_pkg::addr_t     awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    // Write response
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    // Read address and data
    input  regs_pkg::addr_t     araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    // Mixer configuration and status
    mix_cfg_if.regs             cfg,
    input  audio_pkg::sample8_t adc_sample,
    input  logic                tapein
);

    // Control state
    audio_pkg::mute_t    mute_r;
    logic                rs_en_r;
    audio_pkg::sample8_t covox_r;

    logic                wr_accept;
    logic                rd_accept;
    logic [31:0]         rd_word;
    regs_pkg::resp_t     rd_resp;

    // ----------------------------------------
    // Write channel
    // ----------------------------------------

    // Address and data taken together once the previous response is gone
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    always_ff @(posedge clk24) begin
        if (rst) begin
            bvalid  <= 1'b0;
            bresp   <= regs_pkg::resp_okay;
            mute_r  <= '0;
            rs_en_r <= 1'b0;
            covox_r <= '0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
            case (awaddr)
                regs_pkg::reg_ctrl: begin
                    mute_r  <= wdata[regs_pkg::ctrl_mute_lsb +: $bits(audio_pkg::mute_t)];
                    rs_en_r <= wdata[regs_pkg::ctrl_rs_enable];
                    bresp   <= regs_pkg::resp_okay;
                end
                regs_pkg::reg_covox: begin
                    covox_r <= wdata[7:0];
                    bresp   <= regs_pkg::resp_okay;
                end
                // Status registers and holes
                default: bresp <= regs_pkg::resp_slverr;
            endcase
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Configuration straight from the registers
    assign cfg.mute      = mute_r;
    assign cfg.rs_enable = rs_en_r;
    assign cfg.covox     = covox_r;

    // ----------------------------------------
    // Read channel
    // ----------------------------------------

    // One read outstanding at a time
    assign arready   = !rvalid;
    assign rd_accept = arvalid && arready;

    // Read data assembly, live level and ADC status
    always_comb begin
        rd_word = '0;
        rd_resp = regs_pkg::resp_okay;
        case (araddr)
            regs_pkg::reg_ctrl: begin
                rd_word[regs_pkg::ctrl_mute_lsb +: $bits(audio_pkg::mute_t)] = mute_r;
                rd_word[regs_pkg::ctrl_rs_enable] = rs_en_r;
            end
            regs_pkg::reg_covox: rd_word[7:0]  = covox_r;
            regs_pkg::reg_adc:   rd_word[8:0]  = {tapein, adc_sample};
            regs_pkg::reg_level: rd_word[15:0] = cfg.level;
            default:             rd_resp       = regs_pkg::resp_slverr;
        endcase
    end

    always_ff @(posedge clk24) begin
        if (rst) begin
            rvalid <= 1'b0;
            rresp  <= regs_pkg::resp_okay;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
            rresp  <= rd_resp;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Data captured at acceptance and held through back-pressure
    always_ff @(posedge clk24) begin
        if (rd_accept) begin
            rdata <= rd_word;
        end
    end

    // ----------------------------------------
    // Protocol checks
    // ----------------------------------------

    // Responses stay put until the master takes them
    b_hold: assert property (@(posedge clk24) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));
    r_hold: assert property (@(posedge clk24) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    // Full-word writes only
    w_full: assert property (@(posedge clk24) disable iff (rst)
        wr_accept |-> wstrb == 4'hf);

endmodule

// File: src/delta_sigma_dac.sv
// First-order delta-sigma modulator on the top bits of the level
// Updates once per 8 clocks so pwm holds each value for 8 clocks
// Drive a transistor or RC filter from pwm

`timescale 1ns/1ps
`include "audio_macros.svh"

module delta_sigma_dac (
    input  logic              clk24,
    input  logic              rst,
    input  audio_pkg::level_t level,
    output logic              pwm
);

    logic [`AUDIO_DS_DIV_BITS-1:0] div_cnt;
    logic                          ds_ce;
    // Carry bit on top of the running remainder
    logic [`AUDIO_PWM_WIDTH:0]     accu;

    // ----------------------------------------
    // Enable divider
    // ----------------------------------------
    always_ff @(posedge clk24) begin
        if (rst) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign ds_ce = (div_cnt == '0);

    // ----------------------------------------
    // Accumulator
    // ----------------------------------------

    // Remainder plus the top of the level, overflow lands in the carry
    always_ff @(posedge clk24) begin
        if (rst) begin
            accu <= '0;
        end else if (ds_ce) begin
            accu <= {1'b0, accu[`AUDIO_PWM_WIDTH-1:0]}
                  + {1'b0, level[$bits(audio_pkg::level_t)-1 -: `AUDIO_PWM_WIDTH]};
        end
    end

    assign pwm = accu[`AUDIO_PWM_WIDTH];

    // Modulator state moves only on the divided enable
    accu_ce: assert property (@(posedge clk24) disable iff (rst)
        !ds_ce |=> $stable(accu));

endmodule

// File: src/mix_cfg_if.sv
// Mixer configuration from the register block and the mixed level back
// No clock inside, both ends sample on their own clk24

`timescale 1ns/1ps

interface mix_cfg_if;

    // Covox byte written by the host
    audio_pkg::sample8_t covox;

    // Per-source mute mask
    audio_pkg::mute_t mute;

    // Second music chip enable
    logic rs_enable;

    // Registered mixer output for status reads
    audio_pkg::level_t level;

    // Register side drives configuration
    modport regs (output covox, output mute, output rs_enable, input level);

    // Mixer side consumes configuration
    modport mixer (input covox, input mute, input rs_enable, output level);

endinterface

// File: src/regs_pkg.sv
// Register map of the AXI4-Lite control slave
// Offsets are byte addresses on a 4-bit address bus

package regs_pkg;

    // Register address as seen on awaddr and araddr
    typedef logic [3:0] addr_t;

    // AXI response code
    typedef logic [1:0] resp_t;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    localparam addr_t reg_ctrl  = 4'h0;
    localparam addr_t reg_covox = 4'h4;
    localparam addr_t reg_adc   = 4'h8;
    localparam addr_t reg_level = 4'hc;

    // Control register bit positions
    localparam int ctrl_mute_lsb  = 0;
    localparam int ctrl_rs_enable = 4;

    // Responses used by the slave
    localparam resp_t resp_okay   = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

endpackage

// File: src/sound_codec.sv
// Audio block top level with plain ports
// Host control over AXI4-Lite with 4-bit byte addresses
// Sound output is a 1-bit stream on pwm at 24 MHz

`timescale 1ns/1ps

module sound_codec (
    input  logic        clk24,
    input  logic        rst,
    // Sound sources
    input  logic [3:0]  pulses,
    input  logic [7:0]  ay_a,
    input  logic [7:0]  ay_b,
    input  logic [7:0]  ay_c,
    input  logic [7:0]  rs_a,
    input  logic [7:0]  rs_b,
    input  logic [7:0]  rs_c,
    // AXI4-Lite write
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    // AXI4-Lite read
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // Tape ADC
    input  logic        adc_data,
    output logic        adc_clk,
    output logic        adc_cs_n,
    output logic        tapein,
    // Speaker
    output logic        pwm
);

    // Mixer configuration bus
    mix_cfg_if cfg_bus ();

    logic [15:0] level;
    logic [7:0]  adc_sample;

    // ----------------------------------------
    // Control registers
    // ----------------------------------------
    audio_regs u_regs (
        .clk24      (clk24),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .cfg        (cfg_bus.regs),
        .adc_sample (adc_sample),
        .tapein     (tapein)
    );

    // ----------------------------------------
    // Sound path
    // ----------------------------------------
    sound_mixer u_mixer (
        .clk24  (clk24),
        .rst    (rst),
        .pulses (pulses),
        .ay_a   (ay_a),
        .ay_b   (ay_b),
        .ay_c   (ay_c),
        .rs_a   (rs_a),
        .rs_b   (rs_b),
        .rs_c   (rs_c),
        .cfg    (cfg_bus.mixer),
        .level  (level)
    );

    delta_sigma_dac u_dac (
        .clk24 (clk24),
        .rst   (rst),
        .level (level),
        .pwm   (pwm)
    );

    // Tape input
    tape_adc_reader u_adc (
        .clk24      (clk24),
        .rst        (rst),
        .adc_data   (adc_data),
        .adc_clk    (adc_clk),
        .adc_cs_n   (adc_cs_n),
        .adc_sample (adc_sample),
        .tapein     (tapein)
    );

endmodule

// File: src/sound_mixer.sv
// Saturating mix of beeper, two music chips and covox
// The second chip halves the first chip's gain when enabled
// Level lags its inputs by one clock

`timescale 1ns/1ps

module sound_mixer (
    input  logic                clk24,
    input  logic                rst,
    input  logic [3:0]          pulses,
    input  audio_pkg::sample8_t ay_a,
    input  audio_pkg::sample8_t ay_b,
    input  audio_pkg::sample8_t ay_c,
    input  audio_pkg::sample8_t rs_a,
    input  audio_pkg::sample8_t rs_b,
    input  audio_pkg::sample8_t rs_c,
    mix_cfg_if.mixer            cfg,
    output audio_pkg::level_t   level
);

    logic [2:0]  beep_sum;
    logic [9:0]  ay_sum;
    logic [9:0]  rs_sum;
    // One spare bit above the level for overflow
    logic [16:0] beep_term;
    logic [16:0] ay_term;
    logic [16:0] rs_term;
    logic [16:0] covox_term;
    logic [16:0] total;

    always_comb begin
        // Timer channel 3 counts double
        beep_sum = {2'b0, pulses[0]} + {2'b0, pulses[1]} + {2'b0, pulses[2]}
                 + {1'b0, pulses[3], 1'b0};
        ay_sum   = {2'b0, ay_a} + {2'b0, ay_b} + {2'b0, ay_c};
        rs_sum   = {2'b0, rs_a} + {2'b0, rs_b} + {2'b0, rs_c};

        // Beeper scaled by 8192
        beep_term = {1'b0, beep_sum, 13'b0};
        // Shared gain of 16 each when both chips play
        if (cfg.rs_enable) begin
            ay_term = {3'b0, ay_sum, 4'b0};
            rs_term = {3'b0, rs_sum, 4'b0};
        end else begin
            ay_term = {2'b0, ay_sum, 5'b0};
            rs_term = '0;
        end
        covox_term = {5'b0, cfg.covox, 4'b0};

        // Muted sources drop out
        if (cfg.mute[audio_pkg::src_beep])  beep_term  = '0;
        if (cfg.mute[audio_pkg::src_ay])    ay_term    = '0;
        if (cfg.mute[audio_pkg::src_rs])    rs_term    = '0;
        if (cfg.mute[audio_pkg::src_covox]) covox_term = '0;

        total = beep_term + ay_term + rs_term + covox_term;
    end

    // Clip at full scale
    always_ff @(posedge clk24) begin
        if (rst) begin
            level <= '0;
        end else begin
            level <= total[16] ? 16'hffff : total[15:0];
        end
    end

    assign cfg.level = level;

endmodule

// File: src/tape_adc_reader.sv
// Frame sequencer for a TLC549-style serial ADC on the tape input
// Data is sampled as adc_clk rises and must change only after it falls
// The first frame after reset returns a stale conversion

`timescale 1ns/1ps
`include "audio_macros.svh"

module tape_adc_reader (
    input  logic                clk24,
    input  logic                rst,
    input  logic                adc_data,
    output logic                adc_clk,
    output logic                adc_cs_n,
    output audio_pkg::sample8_t adc_sample,
    output logic                tapein
);

    logic [`ADC_CLK_DIV_BITS-1:0]     bit_tmr;
    logic [$clog2(`ADC_FRAME_BITS)-1:0] frame_cnt;
    logic                             shifting;
    logic                             second_half;
    logic                             sample_pt;
    logic                             last_bit;
    audio_pkg::sample8_t              shift_reg;
    logic                             sample_done;

    // ----------------------------------------
    // Bit timer and frame counter
    // ----------------------------------------
    always_ff @(posedge clk24) begin
        if (rst) begin
            bit_tmr   <= '0;
            frame_cnt <= '0;
        end else begin
            bit_tmr <= bit_tmr + 1'b1;
            // Advance at the end of each bit period
            if (&bit_tmr) begin
                if (int'(frame_cnt) == `ADC_FRAME_BITS - 1) begin
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // Chip selected for the first 8 bit periods
    assign shifting    = int'(frame_cnt) < $bits(audio_pkg::sample8_t);
    assign second_half = bit_tmr[`ADC_CLK_DIV_BITS-1];
    // Start of the high half, same edge that raises adc_clk
    assign sample_pt   = shifting && second_half && (bit_tmr[`ADC_CLK_DIV_BITS-2:0] == '0);
    assign last_bit    = int'(frame_cnt) == $bits(audio_pkg::sample8_t) - 1;

    // Registered pins, idle after reset
    always_ff @(posedge clk24) begin
        if (rst) begin
            adc_cs_n <= 1'b1;
            adc_clk  <= 1'b0;
        end else begin
            adc_cs_n <= !shifting;
            adc_clk  <= shifting && second_half;
        end
    end

    // ----------------------------------------
    // Capture
    // ----------------------------------------

    // MSB arrives first
    always_ff @(posedge clk24) begin
        if (sample_pt) begin
            shift_reg <= {shift_reg[6:0], adc_data};
        end
    end

    always_ff @(posedge clk24) begin
        if (rst) begin
            adc_sample  <= '0;
            sample_done <= 1'b0;
        end else begin
            sample_done <= sample_pt && last_bit;
            if (sample_pt && last_bit) begin
                adc_sample <= {shift_reg[6:0], adc_data};
            end
        end
    end

    // Hysteresis around mid-scale, holds inside the band
    always_ff @(posedge clk24) begin
        if (rst) begin
            tapein <= 1'b0;
        end else if (sample_done) begin
            if (int'(adc_sample) > 128 + `AUDIO_HYST) begin
                tapein <= 1'b1;
            end else if (int'(adc_sample) < 128 - `AUDIO_HYST) begin
                tapein <= 1'b0;
            end
        end
    end

    // No clock edges toward a deselected converter
    clk_in_frame: assert property (@(posedge clk24) disable iff (rst)
        adc_clk |-> !adc_cs_n);

endmodule
